//--- src/sensor_pkg.sv
/*
 * shared widths, seeds and types for the sensor timing and pattern source
 * import into the module body, use scoped names in port lists
 */

package sensor_pkg;

	// ------------------------------------------------------------------------
	// widths and constants
	// ------------------------------------------------------------------------
	localparam int PIX_W  = 12;               // pixel data width
	localparam int DIM_W  = 16;               // geometry field width
	localparam int LFSR_W = 16;               // both lfsr registers

	localparam logic [LFSR_W-1:0] PAT_LFSR_SEED   = 16'hACE1;   // must be nonzero
	localparam logic [LFSR_W-1:0] NOISE_LFSR_SEED = 16'h1D35;

	localparam int NOISE_MAX = 4;             // noise spans -4 .. +3

	// ------------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------------
	typedef logic [PIX_W-1:0]  pix_t;
	typedef logic [DIM_W-1:0]  dim_t;
	typedef logic [LFSR_W-1:0] lfsr_t;

	// run-time geometry, all fields >= 1
	typedef struct packed {
		dim_t width;          // active pixels per line
		dim_t line_hide;      // lval low between lines
		dim_t height;         // lines per frame
		dim_t frame_hide;     // fval low between frames
		dim_t front_porch;    // fval rise to first lval rise
		dim_t back_porch;     // last lval fall to fval fall
	} timing_cfg_t;

	typedef struct packed {
		logic fval;
		logic lval;
	} sync_t;

	typedef struct packed {
		logic fval;
		logic lval;
		pix_t data;
	} video_t;

	typedef enum logic [1:0] {
		PAT_LINE_INC,
		PAT_FRAME_INC,
		PAT_FRAME_INC_NO_RST,
		PAT_RANDOM
	} pattern_e;

	typedef enum logic [2:0] {
		ST_FRAME_HIDE,
		ST_FRONT_PORCH,
		ST_LINE_ACT,
		ST_LINE_HIDE,
		ST_BACK_PORCH
	} timing_state_e;

	// fibonacci step, taps 16 14 13 11, new bit enters at bit 0
	function automatic lfsr_t lfsr_next(lfsr_t cur);
		return {cur[LFSR_W-2:0], cur[15] ^ cur[13] ^ cur[12] ^ cur[10]};
	endfunction

endpackage

//--- src/sensor_timing_gen.sv
/*
 * stage 1 of the sensor source: fval / lval timing from run-time geometry
 * geometry is latched at every frame start, pause holds in frame hide
 */
`timescale 1ns/100ps

module sensor_timing_gen (
	input  logic                    clk,
	input  logic                    i_arst_n,
	input  sensor_pkg::timing_cfg_t i_cfg,
	input  logic                    i_pause_en,       // hold off next frame
	input  logic                    i_continue_lval,  // line rhythm during frame hide
	output sensor_pkg::sync_t       o_sync
);
	import sensor_pkg::*;

	timing_state_e st_q;
	timing_state_e st_d;
	dim_t          cnt_q;        // cycles spent in current state
	dim_t          cnt_d;
	dim_t          line_q;       // line index within frame
	dim_t          line_d;
	dim_t          rcnt_q;       // rhythm counter, frame hide only
	dim_t          rcnt_d;
	logic          r_hi_q;       // rhythm phase, 1 = lval high part
	logic          r_hi_d;
	logic          first_q;      // no frame started since reset
	logic          frame_start;
	timing_cfg_t   cfg_q;        // latched geometry of current frame
	timing_cfg_t   cfg;          // geometry in effect
	sync_t         sync_d;

	// last cycle of a run of len cycles
	function automatic logic at_end(dim_t cnt, dim_t len);
		return cnt == len - dim_t'(1);
	endfunction

	// before the first frame the live geometry counts the frame hide
	assign cfg = first_q ? i_cfg : cfg_q;

	// ------------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------------
	always_comb begin
		st_d        = st_q;
		cnt_d       = cnt_q + dim_t'(1);
		line_d      = line_q;
		frame_start = 1'b0;
		case (st_q)
			ST_FRAME_HIDE: begin
				if (cnt_q >= cfg.frame_hide - dim_t'(1)) begin
					cnt_d = cnt_q;                       // park here while paused
					if (!i_pause_en) begin
						st_d        = ST_FRONT_PORCH;
						cnt_d       = '0;
						line_d      = '0;
						frame_start = 1'b1;
					end
				end
			end
			ST_FRONT_PORCH: begin
				if (at_end(cnt_q, cfg.front_porch)) begin
					st_d  = ST_LINE_ACT;
					cnt_d = '0;
				end
			end
			ST_LINE_ACT: begin
				if (at_end(cnt_q, cfg.width)) begin
					cnt_d = '0;
					// no line hide after the last line
					st_d  = at_end(line_q, cfg.height) ? ST_BACK_PORCH : ST_LINE_HIDE;
				end
			end
			ST_LINE_HIDE: begin
				if (at_end(cnt_q, cfg.line_hide)) begin
					st_d   = ST_LINE_ACT;
					cnt_d  = '0;
					line_d = line_q + dim_t'(1);
				end
			end
			ST_BACK_PORCH: begin
				if (at_end(cnt_q, cfg.back_porch)) begin
					st_d  = ST_FRAME_HIDE;
					cnt_d = '0;
				end
			end
			default: begin
				st_d  = ST_FRAME_HIDE;
				cnt_d = '0;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// continue-lval rhythm, restarts at every frame hide entry
	// ------------------------------------------------------------------------
	always_comb begin
		r_hi_d = r_hi_q;
		rcnt_d = rcnt_q + dim_t'(1);
		if (st_q != ST_FRAME_HIDE) begin
			r_hi_d = 1'b1;                              // first cycle of hide is high
			rcnt_d = '0;
		end else if (r_hi_q ? at_end(rcnt_q, cfg.width) : at_end(rcnt_q, cfg.line_hide)) begin
			r_hi_d = ~r_hi_q;
			rcnt_d = '0;
		end
	end

	// sync decode, registered once more below
	always_comb begin
		sync_d.fval = (st_q != ST_FRAME_HIDE);
		sync_d.lval = (st_q == ST_LINE_ACT) ||
			((st_q == ST_FRAME_HIDE) && r_hi_q && i_continue_lval);
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			st_q    <= ST_FRAME_HIDE;                   // start in frame hide
			cnt_q   <= '0;
			line_q  <= '0;
			rcnt_q  <= '0;
			r_hi_q  <= 1'b1;
			first_q <= 1'b1;
			o_sync  <= '0;
		end else begin
			st_q   <= st_d;
			cnt_q  <= cnt_d;
			line_q <= line_d;
			rcnt_q <= rcnt_d;
			r_hi_q <= r_hi_d;
			o_sync <= sync_d;
			if (frame_start) begin
				first_q <= 1'b0;
			end
		end
	end

	// geometry snapshot for the whole frame
	always_ff @(posedge clk) begin
		if (frame_start) begin
			cfg_q <= i_cfg;
		end
	end

endmodule

//--- src/pixel_pattern_gen.sv
/*
 * stage 2 of the sensor source: fills valid pixels with the selected pattern
 * sync is delayed by one cycle, data appears in the same cycle
 */
`timescale 1ns/100ps

module pixel_pattern_gen (
	input  logic                 clk,
	input  logic                 i_arst_n,
	input  sensor_pkg::sync_t    i_sync,
	input  sensor_pkg::pattern_e i_pattern,     // sampled on fval rise
	output sensor_pkg::video_t   o_video
);
	import sensor_pkg::*;

	pattern_e pat_q;
	pattern_e pat_cur;
	pix_t     col_q;          // column index, next pixel
	pix_t     col_cur;
	pix_t     frm_q;          // pixel count within frame
	pix_t     frm_cur;
	pix_t     free_q;         // pixel count since reset
	pix_t     pix_d;
	lfsr_t    lfsr_q;
	logic     valid;
	logic     fval_rise;
	logic     lval_rise;
	video_t   video_d;

	// previous sync is the registered output
	assign valid     = i_sync.fval & i_sync.lval;
	assign fval_rise = i_sync.fval & ~o_video.fval;
	assign lval_rise = i_sync.lval & ~o_video.lval;

	// counters restart on the edge itself
	assign col_cur = lval_rise ? '0 : col_q;
	assign frm_cur = fval_rise ? '0 : frm_q;
	assign pat_cur = fval_rise ? i_pattern : pat_q;

	// ------------------------------------------------------------------------
	// pattern select
	// ------------------------------------------------------------------------
	always_comb begin
		case (pat_cur)
			PAT_LINE_INC:         pix_d = col_cur;
			PAT_FRAME_INC:        pix_d = frm_cur;
			PAT_FRAME_INC_NO_RST: pix_d = free_q;
			PAT_RANDOM:           pix_d = lfsr_q[PIX_W-1:0];   // value before the step
			default:              pix_d = '0;
		endcase
		video_d.fval = i_sync.fval;
		video_d.lval = i_sync.lval;
		video_d.data = valid ? pix_d : '0;                  // blank off valid
	end

	// ------------------------------------------------------------------------
	// counters and lfsr
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pat_q   <= PAT_LINE_INC;
			col_q   <= '0;
			frm_q   <= '0;
			free_q  <= '0;
			lfsr_q  <= PAT_LFSR_SEED;
			o_video <= '0;
		end else begin
			pat_q   <= pat_cur;
			col_q   <= col_cur;
			frm_q   <= frm_cur;
			o_video <= video_d;
			if (valid) begin
				col_q  <= col_cur + pix_t'(1);     // all wrap at 2^12
				frm_q  <= frm_cur + pix_t'(1);
				free_q <= free_q + pix_t'(1);
				lfsr_q <= lfsr_next(lfsr_q);       // one step per valid pixel
			end
		end
	end

endmodule

//--- src/sensor_noise.sv
/*
 * stage 3 of the sensor source: optional bounded noise on valid pixels
 * offset -4 .. +3 from an lfsr, result clipped to the pixel range
 */
`timescale 1ns/100ps

module sensor_noise (
	input  logic               clk,
	input  logic               i_arst_n,
	input  sensor_pkg::video_t i_video,
	input  logic               i_noise_en,      // sampled on fval rise
	output sensor_pkg::video_t o_video
);
	import sensor_pkg::*;

	logic                    en_q;
	logic                    en_cur;
	logic                    valid;
	logic                    fval_rise;
	lfsr_t                   lfsr_q;
	logic signed [3:0]       ofs_s;     // -4 .. +3
	logic signed [PIX_W+1:0] sum_s;     // room for sign and carry
	pix_t                    sat;
	video_t                  video_d;

	assign valid     = i_video.fval & i_video.lval;
	assign fval_rise = i_video.fval & ~o_video.fval;
	assign en_cur    = fval_rise ? i_noise_en : en_q;

	// ------------------------------------------------------------------------
	// saturating add
	// ------------------------------------------------------------------------
	always_comb begin
		ofs_s = $signed({1'b0, lfsr_q[2:0]}) - $signed(4'(NOISE_MAX));
		sum_s = $signed({2'b00, i_video.data}) + ofs_s;   // ofs sign extends
		if (sum_s[PIX_W+1]) begin
			sat = '0;                                    // below zero
		end else if (sum_s[PIX_W]) begin
			sat = '1;                                    // above 4095
		end else begin
			sat = sum_s[PIX_W-1:0];
		end
		video_d = i_video;                               // pass through by default
		if (en_cur && valid) begin
			video_d.data = sat;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			en_q    <= 1'b0;
			lfsr_q  <= NOISE_LFSR_SEED;
			o_video <= '0;
		end else begin
			en_q    <= en_cur;
			o_video <= video_d;
			if (valid) begin
				lfsr_q <= lfsr_next(lfsr_q);   // one step per valid pixel
			end
		end
	end

endmodule

//--- src/sensor_source_top.sv
/*
 * sensor source top: timing, pattern and noise stages in a chain
 * o_video trails the timing stage by two cycles
 */
`timescale 1ns/100ps

module sensor_source_top (
	input  logic                    clk,
	input  logic                    i_arst_n,
	input  sensor_pkg::timing_cfg_t i_cfg,            // frame geometry
	input  sensor_pkg::pattern_e    i_pattern,        // pixel pattern
	input  logic                    i_pause_en,
	input  logic                    i_continue_lval,
	input  logic                    i_noise_en,
	output sensor_pkg::video_t      o_video
);
	import sensor_pkg::*;

	sync_t  sync_w;       // stage 1 -> stage 2
	video_t video_pat_w;  // stage 2 -> stage 3

	// ------------------------------------------------------------------------
	// stage 1, fval / lval timing
	// ------------------------------------------------------------------------
	sensor_timing_gen u_timing (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_cfg           (i_cfg),
		.i_pause_en      (i_pause_en),
		.i_continue_lval (i_continue_lval),
		.o_sync          (sync_w)
	);

	// ------------------------------------------------------------------------
	// stage 2, pattern fill
	// ------------------------------------------------------------------------
	pixel_pattern_gen u_pattern (
		.clk       (clk),
		.i_arst_n  (i_arst_n),
		.i_sync    (sync_w),
		.i_pattern (i_pattern),
		.o_video   (video_pat_w)
	);

	// ------------------------------------------------------------------------
	// stage 3, noise and output register
	// ------------------------------------------------------------------------
	sensor_noise u_noise (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_video    (video_pat_w),
		.i_noise_en (i_noise_en),
		.o_video    (o_video)
	);

endmodule

//--- sim/tb_clk_gen.sv
/*
 * testbench clock source, 8 ns period
 */
`timescale 1ns/100ps

module tb_clk_gen (
	output logic o_clk
);
	initial begin
		o_clk = 1'b0;
	end

	always #4 o_clk = ~o_clk;   // half period

endmodule

//--- sim/sensor_source_sva.sv
/*
 * concurrent checks on the sensor source output port
 * bound into sensor_source_top from the testbench
 */
`timescale 1ns/100ps

module sensor_source_sva (
	input logic               clk,
	input logic               i_arst_n,
	input logic               i_continue_lval,
	input sensor_pkg::video_t i_video
);
	import sensor_pkg::*;

	int unsigned fail_cnt = 0;   // failed assertions so far

	// ------------------------------------------------------------------------
	// blanking and sync rules
	// ------------------------------------------------------------------------
	property p_data_blank;
		@(posedge clk) disable iff (!i_arst_n)
			!(i_video.fval && i_video.lval) |-> i_video.data == '0;
	endproperty

	// lval in frame hide only with continue-lval, three register stages back
	property p_lval_in_frame;
		@(posedge clk) disable iff (!i_arst_n)
			($rose(i_video.lval) && !i_video.fval) |-> $past(i_continue_lval, 3);
	endproperty

	property p_reset_zero;
		@(posedge clk) !i_arst_n |-> i_video == '0;
	endproperty

	a_data_blank: assert property (p_data_blank)
		else begin
			$error("pixel data nonzero outside a valid pixel");
			fail_cnt = fail_cnt + 1;
		end
	a_lval_in_frame: assert property (p_lval_in_frame)
		else begin
			$error("lval rose outside a frame without continue-lval");
			fail_cnt = fail_cnt + 1;
		end
	a_reset_zero: assert property (p_reset_zero)
		else begin
			$error("output not zero during reset");
			fail_cnt = fail_cnt + 1;
		end

endmodule

//--- sim/tb_sensor_source.sv
/*
 * directed testbench for the sensor source: geometry, patterns, pause,
 * continue-lval and noise, checked against a model sampled on the falling edge
 */
`timescale 1ns/100ps

module tb_sensor_source;
	import sensor_pkg::*;

	localparam int LIMIT = 2000;             // max samples for any wait

	typedef struct packed {
		video_t v;
		pix_t   free_cnt;    // expected free running count
		pix_t   rnd;         // expected pattern lfsr data
	} sample_t;

	logic        clk;
	logic        i_arst_n;
	logic        i_pause_en;
	logic        i_continue_lval;
	logic        i_noise_en;
	timing_cfg_t i_cfg;
	pattern_e    i_pattern;
	video_t      o_video;
	logic [7:0]  rng_q;                     // stimulus lfsr
	pix_t        free_m;
	lfsr_t       rnd_m;
	sample_t     smp;                       // current output sample
	logic        prev_fval;
	sample_t     frame_q[$];                // one captured frame
	event        sample_ev;

	tb_clk_gen u_clk (.o_clk(clk));

	sensor_source_top dut (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_cfg           (i_cfg),
		.i_pattern       (i_pattern),
		.i_pause_en      (i_pause_en),
		.i_continue_lval (i_continue_lval),
		.i_noise_en      (i_noise_en),
		.o_video         (o_video)
	);

	bind sensor_source_top sensor_source_sva u_sva (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_continue_lval (i_continue_lval),
		.i_video         (o_video)
	);

	// 16 bit fibonacci, taps 16 14 13 11
	function automatic lfsr_t pat_step(lfsr_t s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// 8 bit fibonacci, taps 8 6 5 4, one step per bit
	function automatic int rand_bits(int n);
		int   v;
		logic nb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			nb    = rng_q[7] ^ rng_q[5] ^ rng_q[4] ^ rng_q[3];
			rng_q = {rng_q[6:0], nb};
			v     = (v << 1) | nb;
		end
		return v;
	endfunction

	function automatic timing_cfg_t random_cfg();
		timing_cfg_t c;
		c.width       = dim_t'(rand_bits(3) + 1);   // 1 .. 8
		c.line_hide   = dim_t'(rand_bits(3) + 1);
		c.height      = dim_t'(rand_bits(3) + 1);
		c.frame_hide  = dim_t'(rand_bits(3) + 1);
		c.front_porch = dim_t'(rand_bits(3) + 1);
		c.back_porch  = dim_t'(rand_bits(3) + 1);
		return c;
	endfunction

	// reference model, free count and lfsr value before each valid pixel
	always @(negedge clk) begin
		prev_fval = smp.v.fval;
		smp       = {o_video, free_m, rnd_m[PIX_W-1:0]};
		if (!i_arst_n) begin
			free_m = '0;
			rnd_m  = PAT_LFSR_SEED;
		end else if (o_video.fval && o_video.lval) begin
			free_m = free_m + pix_t'(1);
			rnd_m  = pat_step(rnd_m);
		end
		-> sample_ev;
	end

	// ------------------------------------------------------------------------
	// reporting and compare tasks
	// ------------------------------------------------------------------------
	task automatic stop_with_fail(string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// watch the bound checker
	always @(posedge clk) begin
		if (dut.u_sva.fail_cnt != 0)
			stop_with_fail("an assertion on the output port failed");
	end

	task automatic check_pix(string name, pix_t got, pix_t lo, pix_t hi);
		if (got < lo || got > hi)
			stop_with_fail($sformatf("Error at %0t ns: %s got %0d expected %0d..%0d",
				$time, name, got, lo, hi));
	endtask

	task automatic check_dim(string name, dim_t got, dim_t exp);
		if (got != exp)
			stop_with_fail($sformatf("Error at %0t ns: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_sync(string name, sync_t got, sync_t exp);
		if (got != exp)
			stop_with_fail($sformatf("Error at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// ------------------------------------------------------------------------
	// sampling helpers, all bounded
	// ------------------------------------------------------------------------
	task automatic next_sample();
		@(sample_ev);
	endtask

	task automatic wait_frame_start();
		int n;
		n = 0;
		do begin
			next_sample();
			n++;
			if (n > LIMIT) stop_with_fail("timeout waiting for a frame to start");
		end while (!(smp.v.fval && !prev_fval));
	endtask

	task automatic wait_fval_fall();
		int n;
		n = 0;
		while (smp.v.fval) begin
			next_sample();
			n++;
			if (n > LIMIT) stop_with_fail("timeout waiting for fval to fall");
		end
	endtask

	// ends on the first sample after the frame
	task automatic capture_frame(bit fresh);
		if (fresh || !(smp.v.fval && !prev_fval)) wait_frame_start();
		frame_q.delete();
		while (smp.v.fval) begin
			frame_q.push_back(smp);
			next_sample();
			if (frame_q.size() > LIMIT) stop_with_fail("fval stuck high");
		end
	endtask

	// ends on the next fval rise
	task automatic measure_hide(output int n);
		n = 0;
		while (!smp.v.fval) begin
			n++;
			next_sample();
			if (n > LIMIT) stop_with_fail("no frame after frame hide");
		end
	endtask

	function automatic int run_len(int start, logic lv);
		int n;
		n = 0;
		while (start + n < frame_q.size() && frame_q[start + n].v.lval == lv) n++;
		return n;
	endfunction

	task automatic check_frame(timing_cfg_t c, pattern_e pat, bit noisy);
		int   i;
		int   col;
		int   fidx;
		int   changed;      // pixels moved off their pattern value
		pix_t exp;
		pix_t lo;
		pix_t hi;
		fidx    = 0;
		col     = 0;
		changed = 0;
		for (int k = 0; k < frame_q.size(); k++) begin
			if (!frame_q[k].v.lval) begin
				check_pix("o_video.data", frame_q[k].v.data, '0, '0);   // blank
				continue;
			end
			if (k == 0 || !frame_q[k-1].v.lval) col = 0;             // new line
			case (pat)
				PAT_LINE_INC:  exp = pix_t'(col);
				PAT_FRAME_INC: exp = pix_t'(fidx);
				PAT_FRAME_INC_NO_RST: exp = frame_q[k].free_cnt;
				default:       exp = frame_q[k].rnd;
			endcase
			lo = exp;
			hi = exp;
			if (noisy) begin
				lo = (exp < pix_t'(NOISE_MAX)) ? '0 : exp - pix_t'(NOISE_MAX);
				hi = (exp > pix_t'(4095 - NOISE_MAX + 1)) ? '1 : exp + pix_t'(NOISE_MAX - 1);
			end
			check_pix("o_video.data", frame_q[k].v.data, lo, hi);
			if (frame_q[k].v.data != exp) changed++;
			col++;
			fidx++;
		end
		if (noisy && changed == 0)
			stop_with_fail("noise enabled but every pixel kept its pattern value");
		// lval structure of the frame
		i = run_len(0, 1'b0);
		check_dim("front porch", dim_t'(i), c.front_porch);
		for (int ln = 0; ln < c.height; ln++) begin
			check_dim("lval width", dim_t'(run_len(i, 1'b1)), c.width);
			i += run_len(i, 1'b1);
			if (ln < c.height - 1) begin
				check_dim("line hide", dim_t'(run_len(i, 1'b0)), c.line_hide);
				i += run_len(i, 1'b0);
			end
		end
		check_dim("back porch", dim_t'(run_len(i, 1'b0)), c.back_porch);
		i += run_len(i, 1'b0);
		if (i != frame_q.size()) stop_with_fail("more lines in a frame than the height");
	endtask

	task automatic set_mode(pattern_e p, logic noise, logic pause, logic cont);
		@(posedge clk);
		i_pattern       <= p;
		i_noise_en      <= noise;
		i_pause_en      <= pause;
		i_continue_lval <= cont;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset();
		repeat (3) begin
			@(negedge clk);
			check_pix("o_video.data", o_video.data, '0, '0);
			check_sync("o_video sync", sync_t'({o_video.fval, o_video.lval}), '0);
		end
		@(posedge clk);
		i_arst_n <= 1'b1;
		@(negedge clk);
		check_pix("o_video.data", o_video.data, '0, '0);
		check_sync("o_video sync", sync_t'({o_video.fval, o_video.lval}), '0);
	endtask

	// first frame after a mode or geometry change is skipped
	task automatic test_frames(pattern_e p, logic noise, int nframes, bit new_cfg);
		int hide;
		if (new_cfg) begin
			@(posedge clk);
			i_cfg <= random_cfg();
		end
		set_mode(p, noise, 1'b0, 1'b0);
		capture_frame(1'b1);
		for (int f = 0; f < nframes; f++) begin
			capture_frame(1'b0);
			check_frame(i_cfg, p, noise);
			measure_hide(hide);
			check_dim("frame hide", dim_t'(hide), i_cfg.frame_hide);
		end
	endtask

	task automatic test_pause_continue();
		sync_t exp_s;
		int    per;
		per = i_cfg.width + i_cfg.line_hide;
		// pause alone, frame completes, then nothing
		wait_frame_start();
		set_mode(i_pattern, 1'b0, 1'b1, 1'b0);
		wait_fval_fall();
		for (int k = 0; k < 60; k++) begin
			check_sync("o_video sync while paused", sync_t'({smp.v.fval, smp.v.lval}), '0);
			next_sample();
		end
		set_mode(i_pattern, 1'b0, 1'b0, 1'b0);
		wait_frame_start();                     // frames resume
		// pause with continue-lval, rhythm from first hide cycle
		set_mode(i_pattern, 1'b0, 1'b1, 1'b1);
		wait_fval_fall();
		for (int k = 0; k < 60; k++) begin
			exp_s.fval = 1'b0;
			exp_s.lval = (k % per) < i_cfg.width;
			check_sync("o_video sync in hide", sync_t'({smp.v.fval, smp.v.lval}), exp_s);
			check_pix("o_video.data", smp.v.data, '0, '0);
			next_sample();
		end
		set_mode(i_pattern, 1'b0, 1'b0, 1'b0);
		wait_frame_start();
	endtask

	initial begin
		rng_q           = 8'd85;                // seed
		free_m          = '0;
		rnd_m           = PAT_LFSR_SEED;
		i_arst_n        = 1'b1;
		i_cfg           = random_cfg();
		i_pattern       = PAT_LINE_INC;
		i_pause_en      = 1'b0;
		i_continue_lval = 1'b0;
		i_noise_en      = 1'b0;
		#1 i_arst_n = 1'b0;
		test_reset();
		test_frames(PAT_LINE_INC, 1'b0, 1, 1'b0);
		test_frames(PAT_LINE_INC, 1'b0, 1, 1'b1);
		test_frames(PAT_LINE_INC, 1'b0, 1, 1'b1);
		test_frames(PAT_FRAME_INC, 1'b0, 2, 1'b1);
		test_frames(PAT_FRAME_INC_NO_RST, 1'b0, 2, 1'b0);
		test_frames(PAT_RANDOM, 1'b0, 2, 1'b0);
		test_pause_continue();
		test_frames(PAT_LINE_INC, 1'b1, 2, 1'b0);   // noise on
		if (dut.u_sva.fail_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- filelist.f
src/sensor_pkg.sv
src/sensor_timing_gen.sv
src/pixel_pattern_gen.sv
src/sensor_noise.sv
src/sensor_source_top.sv
sim/tb_clk_gen.sv
sim/sensor_source_sva.sv
sim/tb_sensor_source.sv

//--- Bender.yml
package:
  name: sensor_source

sources:
  - src/sensor_pkg.sv
  - src/sensor_timing_gen.sv
  - src/pixel_pattern_gen.sv
  - src/sensor_noise.sv
  - src/sensor_source_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/sensor_source_sva.sv
      - sim/tb_sensor_source.sv
